// ==== Makefile ====
# Verilator simulation of the trap-cycle subsystem

VERILATOR ?= verilator
TOP       ?= trapTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

# Build and run, a $fatal in the testbench gives a failing exit status
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== design/aprTrapRegs.sv ====
//////////////////////////////////////////////////
// APR trap registers
// APB slave with the processor and console trap
// enables and a status view of the trap state
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aprTrapRegs
   import trapPkg::*;
#(
   parameter int unsigned apbAddrW = APB_ADDR_W_DEF
)
(
   input  wire logic                clk,
   input  wire logic                rst,
   // APB slave
   input  wire logic                psel,
   input  wire logic                penable,
   input  wire logic                pwrite,
   input  wire logic [apbAddrW-1:0] paddr,
   input  wire apbDataT             pwdata,
   output apbDataT                  prdata,
   output logic                     pready,
   output logic                     pslverr,
   // Live trap state for the status view
   input  wire logic                trap1,
   input  wire logic                trap2,
   input  wire logic                trapCycle,
   input  wire trapCodeT            trapCode,
   // Control outputs
   output logic                     trapEnable,
   output logic                     consTrapEnable,
   output logic                     clrTrap1Req,
   output logic                     clrTrap2Req
);

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   // Offsets sized to the bus
   localparam logic [apbAddrW-1:0] offApr  = apbAddrW'(REG_APR_CTRL);
   localparam logic [apbAddrW-1:0] offCons = apbAddrW'(REG_CONS_CTRL);
   localparam logic [apbAddrW-1:0] offStat = apbAddrW'(REG_TRAP_STAT);

   logic access;
   logic selApr;
   logic selCons;
   logic selStat;
   logic hit;
   logic wrAccess;

   // Access phase, zero wait states
   assign access   = psel & penable;
   assign selApr   = (paddr == offApr);
   assign selCons  = (paddr == offCons);
   assign selStat  = (paddr == offStat);
   assign hit      = selApr | selCons | selStat;
   assign wrAccess = access & pwrite & hit;

   // Always ready
   assign pready  = 1'b1;
   // Error only for unmapped offsets in the access phase
   assign pslverr = access & ~hit;

   //////////////////////////////////////////////////
   // Enable registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapEnable     <= 1'b0;
         consTrapEnable <= 1'b0;
      end
      else
      begin
         // Processor trap enable, APR bit
         if (wrAccess & selApr)
            trapEnable <= pwdata[0];
         // Console trap enable
         if (wrAccess & selCons)
            consTrapEnable <= pwdata[0];
      end
   end

   //////////////////////////////////////////////////
   // Status write-one-to-clear
   //////////////////////////////////////////////////

   // One-cycle pulses, clear lands on the access edge
   assign clrTrap1Req = wrAccess & selStat & pwdata[STAT_TRAP1];
   assign clrTrap2Req = wrAccess & selStat & pwdata[STAT_TRAP2];

   //////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////

   apbDataT statWord;

   // Status view of live flags and latched decision
   always_comb
   begin
      statWord                                    = '0;
      statWord[STAT_TRAP1]                        = trap1;
      statWord[STAT_TRAP2]                        = trap2;
      statWord[STAT_CYCLE]                        = trapCycle;
      statWord[STAT_CODE_LSB +: $bits(trapCodeT)] = trapCode;
   end

   // Combinational read data, zero outside a read access
   always_comb
   begin
      prdata = '0;
      if (access & ~pwrite)
      begin
         if (selApr)
            prdata[0] = trapEnable;
         else if (selCons)
            prdata[0] = consTrapEnable;
         else if (selStat)
            prdata = statWord;
      end
   end

endmodule

`default_nettype wire

// ==== design/pcTrapFlags.sv ====
//////////////////////////////////////////////////
// PC trap flags
// Holds TRAP1 and TRAP2 of the PC flag word, set
// by overflow events, cleared by microcode or APB
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pcTrapFlags
   import trapPkg::*;
(
   input  wire logic    clk,
   input  wire logic    rst,
   // Microcode side
   input  wire logic    clken,
   input  wire logic    specEn,
   input  wire specSelT specSel,
   // Overflow events, one-cycle pulses
   input  wire logic    ovflEvent,
   input  wire logic    pdlOvflEvent,
   // Software clear pulses from the register block
   input  wire logic    clrTrap1Req,
   input  wire logic    clrTrap2Req,
   // Flag outputs
   output logic         trap1,
   output logic         trap2
);

   //////////////////////////////////////////////////
   // Clear decode
   //////////////////////////////////////////////////

   // CLRTRAPS microcode step, only under clock enable
   logic specClrTraps;
   logic clr1;
   logic clr2;

   assign specClrTraps = clken & specEn & (specSel == SPEC_CLRTRAPS);

   // Either source clears a flag
   assign clr1 = specClrTraps | clrTrap1Req;
   assign clr2 = specClrTraps | clrTrap2Req;

   //////////////////////////////////////////////////
   // Flag registers
   //////////////////////////////////////////////////

   // Set beats clear in the same cycle
   // so an overflow is never lost
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trap1 <= 1'b0;
         trap2 <= 1'b0;
      end
      else
      begin
         // TRAP1 from arithmetic overflow
         if (ovflEvent)
            trap1 <= 1'b1;
         else if (clr1)
            trap1 <= 1'b0;
         // TRAP2 from pushdown overflow
         if (pdlOvflEvent)
            trap2 <= 1'b1;
         else if (clr2)
            trap2 <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== design/trapCycleCtl.sv ====
//////////////////////////////////////////////////
// Trap cycle control
// Decides at LOADNICOND whether the next cycle
// is a trap cycle and latches the trap code
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trapCycleCtl
   import trapPkg::*;
(
   input  wire logic    clk,
   input  wire logic    rst,
   // Microcode side
   input  wire logic    clken,
   input  wire logic    specEn,
   input  wire specSelT specSel,
   // Enables from the register block
   input  wire logic    trapEnable,
   input  wire logic    consTrapEnable,
   // Pending flags from the PC flag word
   input  wire logic    trap1,
   input  wire logic    trap2,
   // Decision to the fetch logic
   output logic         trapCycle,
   output trapCodeT     trapCode
);

   //////////////////////////////////////////////////
   // Decode and decision
   //////////////////////////////////////////////////

   logic     specNicond;
   logic     trapPending;
   logic     trapTake;
   trapCodeT codeNext;

   // LOADNICOND step, sampled under clock enable
   assign specNicond = clken & specEn & (specSel == SPEC_LOADNICOND);

   // Any flag waiting
   assign trapPending = trap1 | trap2;

   // Both enables must agree
   assign trapTake = consTrapEnable & trapEnable & trapPending;

   // Which trap, zero when none is taken
   assign codeNext = trapTake ? {trap2, trap1} : '0;

   //////////////////////////////////////////////////
   // Decision registers
   //////////////////////////////////////////////////

   // Hold between LOADNICOND steps
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapCycle <= 1'b0;
         trapCode  <= '0;
      end
      else if (specNicond)
      begin
         trapCycle <= trapTake;
         trapCode  <= codeNext;
      end
   end

endmodule

`default_nettype wire

// ==== design/trapPkg.sv ====
//////////////////////////////////////////////////
// Trap package
// Shared types and constants for the trap-cycle
// logic, the microword special field and APB map
//////////////////////////////////////////////////

`default_nettype none

package trapPkg;

   // Microword special-select field
   typedef logic [5:0] specSelT;

   // Next-instruction condition load step
   localparam specSelT SPEC_LOADNICOND = 6'o10;
   // Clear both trap flags once the trap is taken
   localparam specSelT SPEC_CLRTRAPS   = 6'o22;

   // Trap number, bit 1 is TRAP2 and bit 0 is TRAP1
   typedef logic [1:0] trapCodeT;

   // APB data word
   typedef logic [31:0] apbDataT;

   // Default APB address width
   localparam int unsigned APB_ADDR_W_DEF = 4;

   // Register offsets
   localparam int unsigned REG_APR_CTRL  = 'h0;
   localparam int unsigned REG_CONS_CTRL = 'h4;
   localparam int unsigned REG_TRAP_STAT = 'h8;

   // Status word bit positions
   localparam int unsigned STAT_TRAP1    = 0;
   localparam int unsigned STAT_TRAP2    = 1;
   localparam int unsigned STAT_CYCLE    = 2;
   localparam int unsigned STAT_CODE_LSB = 4;

endpackage

`default_nettype wire

// ==== design/trapTop.sv ====
//////////////////////////////////////////////////
// Trap subsystem top
// Joins the PC trap flags, the APB trap register
// block and the trap-cycle decision
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trapTop
   import trapPkg::*;
#(
   parameter int unsigned apbAddrW = APB_ADDR_W_DEF
)
(
   input  wire logic                clk,
   input  wire logic                rst,
   // Microcode side
   input  wire logic                clken,
   input  wire logic                specEn,
   input  wire specSelT             specSel,
   // Overflow events
   input  wire logic                ovflEvent,
   input  wire logic                pdlOvflEvent,
   // APB slave
   input  wire logic                psel,
   input  wire logic                penable,
   input  wire logic                pwrite,
   input  wire logic [apbAddrW-1:0] paddr,
   input  wire apbDataT             pwdata,
   output apbDataT                  prdata,
   output logic                     pready,
   output logic                     pslverr,
   // Trap decision
   output logic                     trapCycle,
   output trapCodeT                 trapCode
);

   // Internal nets
   logic trapEnable;
   logic consTrapEnable;
   logic clrTrap1Req;
   logic clrTrap2Req;
   logic trap1;
   logic trap2;

   // Flags
   pcTrapFlags uFlags (
      .clk          (clk),
      .rst          (rst),
      .clken        (clken),
      .specEn       (specEn),
      .specSel      (specSel),
      .ovflEvent    (ovflEvent),
      .pdlOvflEvent (pdlOvflEvent),
      .clrTrap1Req  (clrTrap1Req),
      .clrTrap2Req  (clrTrap2Req),
      .trap1        (trap1),
      .trap2        (trap2)
   );

   // Registers
   aprTrapRegs #(.apbAddrW(apbAddrW)) uRegs (
      .clk (clk), .rst (rst),
      .psel (psel), .penable (penable), .pwrite (pwrite),
      .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
      .pready (pready), .pslverr (pslverr),
      .trap1 (trap1), .trap2 (trap2),
      .trapCycle (trapCycle), .trapCode (trapCode),
      .trapEnable (trapEnable), .consTrapEnable (consTrapEnable),
      .clrTrap1Req (clrTrap1Req), .clrTrap2Req (clrTrap2Req)
   );

   // Decision
   trapCycleCtl uCtl (
      .clk (clk), .rst (rst),
      .clken (clken), .specEn (specEn), .specSel (specSel),
      .trapEnable (trapEnable), .consTrapEnable (consTrapEnable),
      .trap1 (trap1), .trap2 (trap2),
      .trapCycle (trapCycle), .trapCode (trapCode)
   );

endmodule

`default_nettype wire

// ==== test/trapTb.sv ====
//////////////////////////////////////////////////
// Trap subsystem testbench
// Directed tests of the trap flags, the APB trap
// registers and the trap-cycle decision
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trapTb
   import trapPkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int unsigned ADDR_W = APB_ADDR_W_DEF;
   localparam int RAND_STEPS = 200;
   // Cycle budget of reset plus each test in order
   localparam int EST_CYCLES = 5 + 20 + 100 + 8 * 40 + 80 + 80 + RAND_STEPS * 10;
   localparam int WATCHDOG_NS = 2 * EST_CYCLES * CLK_PERIOD;

   logic              clk;
   logic              rst;
   logic              clken;
   logic              specEn;
   specSelT           specSel;
   logic              ovflEvent;
   logic              pdlOvflEvent;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [ADDR_W-1:0] paddr;
   apbDataT           pwdata;
   apbDataT           prdata;
   logic              pready;
   logic              pslverr;
   logic              trapCycle;
   trapCodeT          trapCode;

   // Reference model state
   logic              mTrap1;
   logic              mTrap2;
   logic              mEn;
   logic              mCons;
   logic              mCycle;
   trapCodeT          mCode;

   trapTop #(.apbAddrW(ADDR_W)) UUT (
      .clk          (clk),
      .rst          (rst),
      .clken        (clken),
      .specEn       (specEn),
      .specSel      (specSel),
      .ovflEvent    (ovflEvent),
      .pdlOvflEvent (pdlOvflEvent),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .trapCycle    (trapCycle),
      .trapCode     (trapCode)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      failRun("Timeout, the tests did not finish within the expected time");
   end

   //////////////////////////////////////////////////
   // Checking and model helpers
   //////////////////////////////////////////////////

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input apbDataT got, input apbDataT exp);
      assert (got === exp)
      else
         failRun($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
   endtask

   // Status layout with flags in bits 0 and 1, cycle in 2 and code in 5..4
   function automatic apbDataT expectedStatus();
      apbDataT w;
      w      = '0;
      w[0]   = mTrap1;
      w[1]   = mTrap2;
      w[2]   = mCycle;
      w[5:4] = mCode;
      return w;
   endfunction

   //////////////////////////////////////////////////
   // APB and microcode drivers
   //////////////////////////////////////////////////

   task automatic apbRead(input int unsigned addr, output apbDataT data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = ADDR_W'(addr);
      @(negedge clk);
      penable = 1'b1;
      // Sample ahead of the completing edge
      #1;
      data = prdata;
      err  = pslverr;
      checkValue("pready", 32'(pready), 32'h1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apbWrite(input int unsigned addr, input apbDataT data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = ADDR_W'(addr);
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      err = pslverr;
      checkValue("pready", 32'(pready), 32'h1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      // Unmapped writes leave the model alone
      if (addr == REG_APR_CTRL)
         mEn = data[0];
      else if (addr == REG_CONS_CTRL)
         mCons = data[0];
      else if (addr == REG_TRAP_STAT)
      begin
         if (data[0])
            mTrap1 = 1'b0;
         if (data[1])
            mTrap2 = 1'b0;
      end
   endtask

   // One cycle of events and microword special field
   task automatic cycleStep(input logic ov, input logic pdl, input logic ce,
                            input logic se, input specSelT sel);
      logic doNicond;
      logic doClr;
      doNicond = ce & se & (sel == SPEC_LOADNICOND);
      doClr    = ce & se & (sel == SPEC_CLRTRAPS);
      @(negedge clk);
      ovflEvent    = ov;
      pdlOvflEvent = pdl;
      clken        = ce;
      specEn       = se;
      specSel      = sel;
      @(negedge clk);
      ovflEvent    = 1'b0;
      pdlOvflEvent = 1'b0;
      clken        = 1'b0;
      specEn       = 1'b0;
      specSel      = '0;
      // Decision uses the flags from before the edge
      if (doNicond)
      begin
         mCycle = mCons & mEn & (mTrap1 | mTrap2);
         mCode  = mCycle ? {mTrap2, mTrap1} : 2'b00;
      end
      // Set wins over clear
      if (ov)
         mTrap1 = 1'b1;
      else if (doClr)
         mTrap1 = 1'b0;
      if (pdl)
         mTrap2 = 1'b1;
      else if (doClr)
         mTrap2 = 1'b0;
   endtask

   task automatic checkState();
      apbDataT data;
      logic    err;
      checkValue("trapCycle", 32'(trapCycle), 32'(mCycle));
      checkValue("trapCode", 32'(trapCode), 32'(mCode));
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("pslverr", 32'(err), 32'h0);
      checkValue("prdata status", data, expectedStatus());
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic resetState();
      apbDataT data;
      logic    err;
      checkValue("trapCycle", 32'(trapCycle), 32'h0);
      checkValue("trapCode", 32'(trapCode), 32'h0);
      apbRead(REG_APR_CTRL, data, err);
      checkValue("prdata aprCtrl", data, 32'h0);
      apbRead(REG_CONS_CTRL, data, err);
      checkValue("prdata consCtrl", data, 32'h0);
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("prdata status", data, 32'h0);
   endtask

   task automatic registerAccess();
      apbDataT wrApr;
      apbDataT wrCons;
      apbDataT data;
      logic    err;
      repeat (8)
      begin
         wrApr  = $urandom;
         wrCons = $urandom;
         apbWrite(REG_APR_CTRL, wrApr, err);
         checkValue("pslverr", 32'(err), 32'h0);
         apbWrite(REG_CONS_CTRL, wrCons, err);
         checkValue("pslverr", 32'(err), 32'h0);
         apbRead(REG_APR_CTRL, data, err);
         checkValue("prdata aprCtrl", data, wrApr & 32'h1);
         apbRead(REG_CONS_CTRL, data, err);
         checkValue("prdata consCtrl", data, wrCons & 32'h1);
      end
      // Unmapped offsets
      apbRead('hC, data, err);
      checkValue("pslverr", 32'(err), 32'h1);
      checkValue("prdata unmapped", data, 32'h0);
      apbRead('h2, data, err);
      checkValue("pslverr", 32'(err), 32'h1);
      checkValue("prdata unmapped", data, 32'h0);
      // Both enables low so a stray write would show
      apbWrite(REG_APR_CTRL, 32'h0, err);
      apbWrite(REG_CONS_CTRL, 32'h0, err);
      apbWrite('hC, 32'hFFFF_FFFF, err);
      checkValue("pslverr", 32'(err), 32'h1);
      // Enables untouched by the bad write
      apbRead(REG_APR_CTRL, data, err);
      checkValue("prdata aprCtrl", data, 32'h0);
      apbRead(REG_CONS_CTRL, data, err);
      checkValue("prdata consCtrl", data, 32'h0);
   endtask

   task automatic decisionTable();
      int unsigned combo;
      trapCodeT    pend;
      logic        err;
      for (combo = 0; combo < 8; combo++)
      begin
         // No pending trap at the start of each case
         cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_CLRTRAPS);
         apbWrite(REG_APR_CTRL, 32'(combo[0]), err);
         apbWrite(REG_CONS_CTRL, 32'(combo[1]), err);
         pend = combo[2] ? 2'($urandom_range(1, 3)) : 2'b00;
         if (pend != 2'b00)
            cycleStep(pend[0], pend[1], 1'b0, 1'b0, '0);
         cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_LOADNICOND);
         // All three terms high only for combo 7
         checkValue("trapCycle", 32'(trapCycle), 32'(combo == 7));
         checkValue("trapCode", 32'(trapCode), (combo == 7) ? 32'(pend) : 32'h0);
         checkState();
      end
   endtask

   task automatic flagSetAndCode();
      int       i;
      trapCodeT pat;
      logic     err;
      apbWrite(REG_APR_CTRL, 32'h1, err);
      apbWrite(REG_CONS_CTRL, 32'h1, err);
      for (i = 1; i < 4; i++)
      begin
         pat = 2'(i);
         cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_CLRTRAPS);
         cycleStep(pat[0], pat[1], 1'b0, 1'b0, '0);
         cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_LOADNICOND);
         checkValue("trapCycle", 32'(trapCycle), 32'h1);
         checkValue("trapCode", 32'(trapCode), 32'(pat));
         checkState();
      end
      // Gated steps hold the last decision
      cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_CLRTRAPS);
      cycleStep(1'b0, 1'b0, 1'b0, 1'b1, SPEC_LOADNICOND);
      checkValue("trapCycle", 32'(trapCycle), 32'h1);
      cycleStep(1'b0, 1'b0, 1'b1, 1'b0, SPEC_LOADNICOND);
      checkValue("trapCycle", 32'(trapCycle), 32'h1);
      checkState();
      // Enabled step with nothing pending drops it
      cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_LOADNICOND);
      checkValue("trapCycle", 32'(trapCycle), 32'h0);
      checkState();
   endtask

   task automatic flagClearing();
      apbDataT data;
      logic    err;
      cycleStep(1'b1, 1'b1, 1'b0, 1'b0, '0);
      cycleStep(1'b0, 1'b0, 1'b1, 1'b1, SPEC_CLRTRAPS);
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("status flags", data & 32'h3, 32'h0);
      // Write one to clear TRAP1 only
      cycleStep(1'b1, 1'b1, 1'b0, 1'b0, '0);
      apbWrite(REG_TRAP_STAT, 32'h1, err);
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("status flags", data & 32'h3, 32'h2);
      // Then TRAP2 only
      cycleStep(1'b1, 1'b1, 1'b0, 1'b0, '0);
      apbWrite(REG_TRAP_STAT, 32'h2, err);
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("status flags", data & 32'h3, 32'h1);
      // Event beside CLRTRAPS keeps its flag
      cycleStep(1'b1, 1'b1, 1'b0, 1'b0, '0);
      cycleStep(1'b1, 1'b0, 1'b1, 1'b1, SPEC_CLRTRAPS);
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("status flags", data & 32'h3, 32'h1);
      cycleStep(1'b0, 1'b1, 1'b1, 1'b1, SPEC_CLRTRAPS);
      apbRead(REG_TRAP_STAT, data, err);
      checkValue("status flags", data & 32'h3, 32'h2);
      checkState();
   endtask

   task automatic randomSequence();
      int          n;
      int unsigned op;
      logic        err;
      logic        ce;
      logic        se;
      for (n = 0; n < RAND_STEPS; n++)
      begin
         op = $urandom_range(0, 5);
         case (op)
            0: cycleStep(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), 1'b0, 1'b0, '0);
            1: apbWrite(($urandom_range(0, 1) != 0) ? REG_APR_CTRL : REG_CONS_CTRL,
                        $urandom, err);
            2: apbWrite(REG_TRAP_STAT, $urandom, err);
            3: cycleStep(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                         1'b1, 1'b1, SPEC_CLRTRAPS);
            default:
            begin
               // Mostly enabled and sometimes gated
               ce = ($urandom_range(0, 3) != 0);
               se = ($urandom_range(0, 3) != 0);
               cycleStep(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                         ce, se, SPEC_LOADNICOND);
               checkState();
            end
         endcase
      end
      checkState();
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      void'($urandom(27));
      rst          = 1'b1;
      clken        = 1'b0;
      specEn       = 1'b0;
      specSel      = '0;
      ovflEvent    = 1'b0;
      pdlOvflEvent = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      mTrap1       = 1'b0;
      mTrap2       = 1'b0;
      mEn          = 1'b0;
      mCons        = 1'b0;
      mCycle       = 1'b0;
      mCode        = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      resetState();
      registerAccess();
      decisionTable();
      flagSetAndCode();
      flagClearing();
      randomSequence();
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/trapPkg.sv
design/pcTrapFlags.sv
design/aprTrapRegs.sv
design/trapCycleCtl.sv
design/trapTop.sv
test/trapTb.sv
